// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - axi_pkg.sv
  - soc_map_pkg.sv
  - axil_arbiter.sv
  - axil_xbar.sv
  - axil_sram.sv
  - axil_clint.sv
  - axil_uart_tx.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv

// ==== axi_pkg.sv ====
package axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Master to slave
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  rready;
        logic  bready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic  arready;
        data_t rdata;
        resp_t rresp;
        logic  rvalid;
        logic  awready;
        logic  wready;
        resp_t bresp;
        logic  bvalid;
    } axil_rsp_t;

    // Byte lane merge under write strobes
    function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== axil_arbiter.sv ====
`timescale 1ns/1ns

module axil_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t m0_req,
    output axi_pkg::axil_rsp_t m0_rsp,
    input  axi_pkg::axil_req_t m1_req,
    output axi_pkg::axil_rsp_t m1_rsp,
    output axi_pkg::axil_req_t bus_req,
    input  axi_pkg::axil_rsp_t bus_rsp
);

    logic busy;
    logic owner;
    logic rr_ptr;
    logic grant;
    logic m0_want;
    logic m1_want;
    logic done;
    logic addr_hs;

    assign m0_want = m0_req.arvalid || m0_req.awvalid;
    assign m1_want = m1_req.arvalid || m1_req.awvalid;

    // Locked owner wins, otherwise pointer breaks a tie
    always_comb begin
        if (busy) begin
            grant = owner;
        end else if (m0_want && m1_want) begin
            grant = rr_ptr;
        end else begin
            grant = m1_want;
        end
    end

    assign bus_req = grant ? m1_req : m0_req;
    assign m0_rsp  = grant ? axi_pkg::axil_rsp_t'('0) : bus_rsp;
    assign m1_rsp  = grant ? bus_rsp : axi_pkg::axil_rsp_t'('0);

    assign done = busy && ((bus_rsp.rvalid && bus_req.rready) ||
                           (bus_rsp.bvalid && bus_req.bready));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            owner  <= 1'b0;
            rr_ptr <= 1'b0;
        end else if (done) begin
            busy   <= 1'b0;
            // Other master gets the next tie
            rr_ptr <= ~owner;
        end else if (!busy && (m0_want || m1_want)) begin
            busy  <= 1'b1;
            owner <= grant;
        end
    end

    assign addr_hs = (bus_req.arvalid && bus_rsp.arready) ||
                     (bus_req.awvalid && bus_rsp.awready);

    // No second address reaches the bus before the response completes
    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        addr_hs |=> !(bus_req.arvalid || bus_req.awvalid) until done);

endmodule

// ==== axil_clint.sv ====
`timescale 1ns/1ns

module axil_clint (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t req,
    output axi_pkg::axil_rsp_t rsp,
    output logic               timer_irq
);

    axi_pkg::data_t mtime;
    axi_pkg::data_t mtimecmp;
    axi_pkg::data_t rdata_q;
    logic           rvalid_q;
    logic           bvalid_q;
    logic           idle;
    logic           rd_hs;
    logic           wr_hs;

    assign idle  = !rvalid_q && !bvalid_q;
    assign rd_hs = req.arvalid && idle;
    assign wr_hs = req.awvalid && req.wvalid && idle;

    always_comb begin
        rsp         = '0;
        rsp.arready = idle;
        rsp.awready = idle;
        rsp.wready  = idle;
        rsp.rdata   = rdata_q;
        rsp.rresp   = axi_pkg::RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.bresp   = axi_pkg::RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
            rvalid_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            timer_irq <= mtime >= mtimecmp;
            mtime     <= mtime + 1'b1;
            // Software write wins over the increment
            if (wr_hs && req.awaddr == soc_map_pkg::CLINT_MTIME_ADDR) begin
                mtime <= axi_pkg::apply_strb(mtime, req.wdata, req.wstrb);
            end
            if (wr_hs && req.awaddr == soc_map_pkg::CLINT_MTIMECMP_ADDR) begin
                mtimecmp <= axi_pkg::apply_strb(mtimecmp, req.wdata, req.wstrb);
            end
            rvalid_q <= rd_hs || (rvalid_q && !req.rready);
            bvalid_q <= wr_hs || (bvalid_q && !req.bready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (req.araddr)
                soc_map_pkg::CLINT_MTIME_ADDR:    rdata_q <= mtime;
                soc_map_pkg::CLINT_MTIMECMP_ADDR: rdata_q <= mtimecmp;
                default:                          rdata_q <= '0;
            endcase
        end
    end

endmodule

// ==== axil_sram.sv ====
`timescale 1ns/1ns

module axil_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t req,
    output axi_pkg::axil_rsp_t rsp
);

    localparam int IDX_W = $clog2(SRAM_WORDS);

    axi_pkg::data_t mem [SRAM_WORDS];
    axi_pkg::data_t rdata_q;
    logic           rvalid_q;
    logic           bvalid_q;
    logic           idle;
    logic           rd_hs;
    logic           wr_hs;

    assign idle  = !rvalid_q && !bvalid_q;
    assign rd_hs = req.arvalid && idle;
    assign wr_hs = req.awvalid && req.wvalid && idle;

    always_comb begin
        rsp         = '0;
        rsp.arready = idle;
        rsp.awready = idle;
        rsp.wready  = idle;
        rsp.rdata   = rdata_q;
        rsp.rresp   = axi_pkg::RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.bresp   = axi_pkg::RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            mem[req.awaddr[IDX_W+1:2]] <=
                axi_pkg::apply_strb(mem[req.awaddr[IDX_W+1:2]], req.wdata, req.wstrb);
        end
        if (rd_hs) begin
            rdata_q <= mem[req.araddr[IDX_W+1:2]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_hs || (rvalid_q && !req.rready);
            bvalid_q <= wr_hs || (bvalid_q && !req.bready);
        end
    end

endmodule

// ==== axil_uart_tx.sv ====
`timescale 1ns/1ns

module axil_uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t req,
    output axi_pkg::axil_rsp_t rsp,
    output logic               tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t         state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]     bit_cnt;
    logic [7:0]     shreg;
    logic           baud_last;
    axi_pkg::data_t rdata_q;
    logic           rvalid_q;
    logic           bvalid_q;
    logic           wr_ok;
    logic           rd_hs;
    logic           wr_hs;

    assign baud_last = baud_cnt == CNT_W'(CLKS_PER_BIT - 1);
    // Writes held off for the whole frame
    assign wr_ok     = state == IDLE && !bvalid_q;
    assign rd_hs     = req.arvalid && !rvalid_q;
    assign wr_hs     = req.awvalid && req.wvalid && wr_ok;

    always_comb begin
        rsp         = '0;
        rsp.arready = !rvalid_q;
        rsp.awready = wr_ok;
        rsp.wready  = wr_ok;
        rsp.rdata   = rdata_q;
        rsp.rresp   = axi_pkg::RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.bresp   = axi_pkg::RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_hs || (rvalid_q && !req.rready);
            bvalid_q <= wr_hs || (bvalid_q && !req.bready);
            baud_cnt <= (state == IDLE || baud_last) ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (wr_hs) begin
                        state <= START;
                        tx    <= 1'b0;
                    end
                end
                START: begin
                    if (baud_last) begin
                        state   <= DATA;
                        tx      <= shreg[0];
                        bit_cnt <= '0;
                    end
                end
                DATA: begin
                    if (baud_last && bit_cnt == 3'd7) begin
                        state <= STOP;
                        tx    <= 1'b1;
                    end else if (baud_last) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx      <= shreg[1];
                    end
                end
                default: begin
                    if (baud_last) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            shreg <= req.wdata[7:0];
        end else if (state == DATA && baud_last) begin
            shreg <= shreg >> 1;
        end
        if (rd_hs) begin
            rdata_q <= axi_pkg::data_t'(state != IDLE);
        end
    end

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        state == IDLE |-> tx);

endmodule

// ==== axil_xbar.sv ====
`timescale 1ns/1ns

module axil_xbar #(
    parameter int SRAM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t up_req,
    output axi_pkg::axil_rsp_t up_rsp,
    output axi_pkg::axil_req_t sram_req,
    output axi_pkg::axil_req_t uart_req,
    output axi_pkg::axil_req_t clint_req,
    input  axi_pkg::axil_rsp_t sram_rsp,
    input  axi_pkg::axil_rsp_t uart_rsp,
    input  axi_pkg::axil_rsp_t clint_rsp
);

    localparam axi_pkg::addr_t SRAM_BYTES = SRAM_WORDS * 4;
    // CLINT registers live in a 128 byte window
    localparam axi_pkg::addr_t CLINT_MASK = 32'hffff_ff80;

    function automatic soc_map_pkg::slave_sel_t decode(axi_pkg::addr_t addr);
        if (addr >= soc_map_pkg::SRAM_BASE && (addr - soc_map_pkg::SRAM_BASE) < SRAM_BYTES) begin
            return soc_map_pkg::SEL_SRAM;
        end else if (addr == soc_map_pkg::UART_DATA_ADDR) begin
            return soc_map_pkg::SEL_UART;
        end else if ((addr & CLINT_MASK) == (soc_map_pkg::CLINT_MTIME_ADDR & CLINT_MASK)) begin
            return soc_map_pkg::SEL_CLINT;
        end
        return soc_map_pkg::SEL_NONE;
    endfunction

    soc_map_pkg::slave_sel_t dec_sel;
    soc_map_pkg::slave_sel_t sel_q;
    soc_map_pkg::slave_sel_t sel;
    axi_pkg::axil_req_t      fwd;
    logic                    active;
    logic                    err_rvalid;
    logic                    err_bvalid;
    logic                    rd_hs;
    logic                    wr_hs;
    logic                    done;

    assign dec_sel = decode(up_req.awvalid ? up_req.awaddr : up_req.araddr);
    assign sel     = active ? sel_q : dec_sel;

    always_comb begin
        fwd = up_req;
        // Address phase closed while a response is pending
        if (active) begin
            fwd.arvalid = 1'b0;
            fwd.awvalid = 1'b0;
            fwd.wvalid  = 1'b0;
        end
        sram_req  = '0;
        uart_req  = '0;
        clint_req = '0;
        up_rsp    = '0;
        case (sel)
            soc_map_pkg::SEL_SRAM: begin
                sram_req = fwd;
                up_rsp   = sram_rsp;
            end
            soc_map_pkg::SEL_UART: begin
                uart_req = fwd;
                up_rsp   = uart_rsp;
            end
            soc_map_pkg::SEL_CLINT: begin
                clint_req = fwd;
                up_rsp    = clint_rsp;
            end
            default: begin
                up_rsp.arready = up_req.arvalid;
                up_rsp.awready = up_req.awvalid && up_req.wvalid;
                up_rsp.wready  = up_req.awvalid && up_req.wvalid;
                up_rsp.rvalid  = err_rvalid;
                up_rsp.rresp   = axi_pkg::RESP_DECERR;
                up_rsp.bvalid  = err_bvalid;
                up_rsp.bresp   = axi_pkg::RESP_DECERR;
            end
        endcase
        if (active) begin
            up_rsp.arready = 1'b0;
            up_rsp.awready = 1'b0;
            up_rsp.wready  = 1'b0;
        end
    end

    assign rd_hs = up_req.arvalid && up_rsp.arready;
    assign wr_hs = up_req.awvalid && up_req.wvalid && up_rsp.awready;
    assign done  = active && ((up_rsp.rvalid && up_req.rready) ||
                              (up_rsp.bvalid && up_req.bready));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            sel_q      <= soc_map_pkg::SEL_NONE;
            err_rvalid <= 1'b0;
            err_bvalid <= 1'b0;
        end else begin
            if (rd_hs || wr_hs) begin
                active <= 1'b1;
                sel_q  <= dec_sel;
            end else if (done) begin
                active <= 1'b0;
            end
            err_rvalid <= (rd_hs && dec_sel == soc_map_pkg::SEL_NONE) ||
                          (err_rvalid && !up_req.rready);
            err_bvalid <= (wr_hs && dec_sel == soc_map_pkg::SEL_NONE) ||
                          (err_bvalid && !up_req.bready);
        end
    end

    // Only one slave holds a response at a time
    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sram_rsp.rvalid || sram_rsp.bvalid,
                  uart_rsp.rvalid || uart_rsp.bvalid,
                  clint_rsp.rvalid || clint_rsp.bvalid}));

endmodule

// ==== soc_bus.f ====
axi_pkg.sv
soc_map_pkg.sv
axil_arbiter.sv
axil_xbar.sv
axil_sram.sv
axil_clint.sv
axil_uart_tx.sv
soc_bus_top.sv
tb_soc_bus.sv

// ==== soc_bus_top.sv ====
`timescale 1ns/1ns

module soc_bus_top #(
    parameter int SRAM_WORDS   = 256,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axil_req_t m0_req,
    output axi_pkg::axil_rsp_t m0_rsp,
    input  axi_pkg::axil_req_t m1_req,
    output axi_pkg::axil_rsp_t m1_rsp,
    output logic               tx,
    output logic               timer_irq
);

    axi_pkg::axil_req_t bus_req;
    axi_pkg::axil_rsp_t bus_rsp;
    axi_pkg::axil_req_t sram_req;
    axi_pkg::axil_rsp_t sram_rsp;
    axi_pkg::axil_req_t uart_req;
    axi_pkg::axil_rsp_t uart_rsp;
    axi_pkg::axil_req_t clint_req;
    axi_pkg::axil_rsp_t clint_rsp;

    axil_arbiter arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .m0_req  (m0_req),
        .m0_rsp  (m0_rsp),
        .m1_req  (m1_req),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    axil_xbar #(.SRAM_WORDS(SRAM_WORDS)) xbar_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_req    (bus_req),
        .up_rsp    (bus_rsp),
        .sram_req  (sram_req),
        .uart_req  (uart_req),
        .clint_req (clint_req),
        .sram_rsp  (sram_rsp),
        .uart_rsp  (uart_rsp),
        .clint_rsp (clint_rsp)
    );

    axil_sram #(.SRAM_WORDS(SRAM_WORDS)) sram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    axil_uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (uart_req),
        .rsp   (uart_rsp),
        .tx    (tx)
    );

    axil_clint clint_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (clint_req),
        .rsp       (clint_rsp),
        .timer_irq (timer_irq)
    );

endmodule

// ==== soc_map_pkg.sv ====
package soc_map_pkg;

    localparam axi_pkg::addr_t SRAM_BASE           = 32'h8000_0000;
    localparam axi_pkg::addr_t UART_DATA_ADDR      = 32'ha000_03f8;
    localparam axi_pkg::addr_t CLINT_MTIME_ADDR    = 32'ha000_0048;
    localparam axi_pkg::addr_t CLINT_MTIMECMP_ADDR = 32'ha000_0050;

    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_UART,
        SEL_CLINT,
        SEL_NONE
    } slave_sel_t;

endpackage

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ns

module tb_soc_bus;

    localparam int SRAM_WORDS   = 256;
    localparam int CLKS_PER_BIT = 8;
    localparam int NUM_WORDS    = 16;
    localparam int LIMIT        = 500;
    localparam axi_pkg::addr_t UNMAPPED_ADDR = 32'h4000_1000;

    logic               clk;
    logic               rst_n;
    axi_pkg::axil_req_t m0_req;
    axi_pkg::axil_rsp_t m0_rsp;
    axi_pkg::axil_req_t m1_req;
    axi_pkg::axil_rsp_t m1_rsp;
    logic               tx;
    logic               timer_irq;

    // Mirror of SRAM contents
    axi_pkg::data_t model [SRAM_WORDS];
    int             seed;
    int             done_count;
    int             done_order [2];
    int             frames_done;
    logic           frame_on;
    axi_pkg::data_t rd, rd0, rd1, wd, t0, t1;
    axi_pkg::resp_t rs, rs0, rs1;
    axi_pkg::strb_t st;
    int             lat, lat0, lat1;
    int             lone;
    logic [7:0]     byte_a, byte_b;

    soc_bus_top #(
        .SRAM_WORDS   (SRAM_WORDS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .m0_req    (m0_req),
        .m0_rsp    (m0_rsp),
        .m1_req    (m1_req),
        .m1_rsp    (m1_rsp),
        .tx        (tx),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input axi_pkg::data_t exp,
                               input axi_pkg::data_t act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    function automatic axi_pkg::data_t merge_bytes(input axi_pkg::data_t old_w,
                                                   input axi_pkg::data_t new_w,
                                                   input axi_pkg::strb_t strb);
        axi_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic int word_index(input int j);
        return (j * 37 + 5) % SRAM_WORDS;
    endfunction

    function automatic axi_pkg::addr_t word_addr(input int j);
        return soc_map_pkg::SRAM_BASE + axi_pkg::addr_t'(word_index(j) * 4);
    endfunction

    task automatic drive_master(input int m, input axi_pkg::axil_req_t r);
        if (m == 0) begin
            m0_req = r;
        end else begin
            m1_req = r;
        end
    endtask

    function automatic axi_pkg::axil_rsp_t response_of(input int m);
        return (m == 0) ? m0_rsp : m1_rsp;
    endfunction

    // Latency counts falling edges from valid to the sampled response
    task automatic read_word(input int m, input axi_pkg::addr_t addr,
                             output axi_pkg::data_t data, output axi_pkg::resp_t resp,
                             output int lat);
        axi_pkg::axil_req_t r;
        axi_pkg::axil_rsp_t rsp;
        int                 cycles;
        r         = '0;
        r.araddr  = addr;
        r.arvalid = 1'b1;
        r.rready  = 1'b1;
        cycles    = 0;
        @(posedge clk);
        #1;
        drive_master(m, r);
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("Timeout waiting for arready");
            rsp = response_of(m);
        end while (!rsp.arready);
        @(posedge clk);
        #1;
        r.arvalid = 1'b0;
        drive_master(m, r);
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("Timeout waiting for rvalid");
            rsp = response_of(m);
        end while (!rsp.rvalid);
        data          = rsp.rdata;
        resp          = rsp.rresp;
        lat           = cycles;
        done_order[m] = done_count;
        done_count++;
        @(posedge clk);
        #1;
        drive_master(m, '0);
    endtask

    task automatic write_word(input int m, input axi_pkg::addr_t addr,
                              input axi_pkg::data_t data, input axi_pkg::strb_t strb,
                              output axi_pkg::resp_t resp, output int lat);
        axi_pkg::axil_req_t r;
        axi_pkg::axil_rsp_t rsp;
        int                 cycles;
        r         = '0;
        r.awaddr  = addr;
        r.awvalid = 1'b1;
        r.wdata   = data;
        r.wstrb   = strb;
        r.wvalid  = 1'b1;
        r.bready  = 1'b1;
        cycles    = 0;
        @(posedge clk);
        #1;
        drive_master(m, r);
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("Timeout waiting for awready and wready");
            rsp = response_of(m);
        end while (!(rsp.awready && rsp.wready));
        @(posedge clk);
        #1;
        r.awvalid = 1'b0;
        r.wvalid  = 1'b0;
        drive_master(m, r);
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("Timeout waiting for bvalid");
            rsp = response_of(m);
        end while (!rsp.bvalid);
        resp          = rsp.bresp;
        lat           = cycles;
        done_order[m] = done_count;
        done_count++;
        @(posedge clk);
        #1;
        drive_master(m, '0);
    endtask

    // Samples each bit near its middle
    task automatic check_frame(input logic [7:0] byte_val);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("Timeout waiting for the UART start bit");
        end while (tx !== 1'b0);
        frame_on = 1'b1;
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        check_value("uart_start_bit", 0, tx);
        for (int b = 0; b < 8; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value("uart_data_bit", byte_val[b], tx);
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("uart_stop_bit", 1, tx);
        frame_on = 1'b0;
        frames_done++;
    endtask

    task automatic wait_irq(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (timer_irq !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run(what);
        end
    endtask

    a_one_response: assert property (@(posedge clk) disable iff (!rst_n)
        !((m0_rsp.rvalid || m0_rsp.bvalid) && (m1_rsp.rvalid || m1_rsp.bvalid)))
        else abort_run("Both masters saw a response in the same cycle");

    a_aw_w_paired: assert property (@(posedge clk) disable iff (!rst_n)
        m1_rsp.awready == m1_rsp.wready)
        else abort_run("awready and wready differ on m1");

    a_uart_held_off: assert property (@(posedge clk) disable iff (!rst_n)
        frame_on && m1_req.awvalid |-> !m1_rsp.awready)
        else abort_run("UART write accepted while a frame was being sent");

    a_decerr_zero: assert property (@(posedge clk) disable iff (!rst_n)
        m1_rsp.rvalid && m1_rsp.rresp == axi_pkg::RESP_DECERR |-> m1_rsp.rdata == '0)
        else abort_run("Decode-error read returned nonzero data");

    initial begin
        seed        = 32'h9f27;
        rst_n       = 1'b0;
        m0_req      = '0;
        m1_req      = '0;
        frame_on    = 1'b0;
        frames_done = 0;
        done_count  = 0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("reset_ready_valid", 0,
                    {m0_rsp.arready, m0_rsp.awready, m0_rsp.wready,
                     m0_rsp.rvalid, m0_rsp.bvalid,
                     m1_rsp.arready, m1_rsp.awready, m1_rsp.wready,
                     m1_rsp.rvalid, m1_rsp.bvalid});
        check_value("reset_tx", 1, tx);
        check_value("reset_irq", 0, timer_irq);
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);

        // Full word first, then a random strobe on top
        for (int i = 0; i < NUM_WORDS; i++) begin
            wd = $random(seed);
            write_word(1, word_addr(i), wd, 4'hf, rs, lat);
            check_value("sram_full_write_resp", axi_pkg::RESP_OKAY, rs);
            model[word_index(i)] = wd;
            wd = $random(seed);
            st = 4'($random(seed));
            write_word(1, word_addr(i), wd, st, rs, lat);
            check_value("sram_strb_write_resp", axi_pkg::RESP_OKAY, rs);
            model[word_index(i)] = merge_bytes(model[word_index(i)], wd, st);
            read_word(1, word_addr(i), rd, rs, lat);
            check_value("sram_readback", model[word_index(i)], rd);
            check_value("sram_read_resp", axi_pkg::RESP_OKAY, rs);
        end

        for (int i = 0; i < NUM_WORDS; i++) begin
            read_word(0, word_addr(i), rd, rs, lat);
            check_value("m0_shared_read", model[word_index(i)], rd);
            check_value("m0_idle_latency", 2, lat);
        end

        // A lone read sets who wins the following tie
        for (int i = 0; i < 8; i++) begin
            lone = i % 2;
            read_word(lone, word_addr(i), rd, rs, lat);
            check_value("arb_lone_read", model[word_index(i)], rd);
            fork
                read_word(0, word_addr(2 * i), rd0, rs0, lat0);
                read_word(1, word_addr(2 * i + 1), rd1, rs1, lat1);
            join
            check_value("arb_m0_data", model[word_index(2 * i)], rd0);
            check_value("arb_m1_data", model[word_index(2 * i + 1)], rd1);
            check_value("arb_m0_resp", axi_pkg::RESP_OKAY, rs0);
            check_value("arb_m1_resp", axi_pkg::RESP_OKAY, rs1);
            check_value("arb_first_done", 1 - lone, (done_order[1] < done_order[0]) ? 1 : 0);
        end

        byte_a = 8'($random(seed));
        byte_b = 8'($random(seed));
        fork
            begin
                check_frame(byte_a);
                check_frame(byte_b);
            end
            begin
                write_word(1, soc_map_pkg::UART_DATA_ADDR, {24'h0, byte_a}, 4'hf, rs, lat);
                check_value("uart_write_resp", axi_pkg::RESP_OKAY, rs);
                repeat (2 * CLKS_PER_BIT) @(posedge clk);
                write_word(1, soc_map_pkg::UART_DATA_ADDR, {24'h0, byte_b}, 4'hf, rs, lat);
                check_value("uart_write_held_off", 1, frames_done >= 1);
                read_word(1, soc_map_pkg::UART_DATA_ADDR, rd, rs, lat);
                check_value("uart_busy_flag", 1, rd);
            end
        join
        repeat (CLKS_PER_BIT) @(negedge clk);
        read_word(1, soc_map_pkg::UART_DATA_ADDR, rd, rs, lat);
        check_value("uart_idle_flag", 0, rd);

        read_word(1, soc_map_pkg::CLINT_MTIME_ADDR, t0, rs, lat);
        read_word(1, soc_map_pkg::CLINT_MTIME_ADDR, t1, rs, lat);
        check_value("mtime_increases", 1, t1 > t0);
        write_word(1, soc_map_pkg::CLINT_MTIMECMP_ADDR, t1 + 40, 4'hf, rs, lat);
        check_value("irq_low_before_cmp", 0, timer_irq);
        read_word(1, soc_map_pkg::CLINT_MTIMECMP_ADDR, rd, rs, lat);
        check_value("mtimecmp_readback", t1 + 40, rd);
        wait_irq(1'b1, "Timeout waiting for timer_irq to rise");
        write_word(1, soc_map_pkg::CLINT_MTIMECMP_ADDR, 32'hffff_ffff, 4'hf, rs, lat);
        wait_irq(1'b0, "Timeout waiting for timer_irq to fall");

        read_word(1, UNMAPPED_ADDR, rd, rs, lat);
        check_value("decerr_read_resp", axi_pkg::RESP_DECERR, rs);
        check_value("decerr_read_data", 0, rd);
        write_word(1, UNMAPPED_ADDR, 32'hdead_beef, 4'hf, rs, lat);
        check_value("decerr_write_resp", axi_pkg::RESP_DECERR, rs);
        read_word(0, word_addr(3), rd, rs, lat);
        check_value("sram_after_decerr", model[word_index(3)], rd);
        check_value("sram_after_decerr_resp", axi_pkg::RESP_OKAY, rs);

        $display("=== PASS ===");
        $finish;
    end

endmodule
